//--- logic/cp0_exc_ctrl.sv
`timescale 1ns/1ps

module cp0_exc_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                exc_req_i,
    input  cp0_pkg::exc_code_t  exc_code_i,
    input  cp0_pkg::cp0_word_t  exc_pc_i,
    input  logic                exc_bd_i,
    input  cp0_pkg::cp0_word_t  bad_vaddr_i,
    input  cp0_pkg::cp0_word_t  cur_pc_i,
    input  logic                eret_i,
    input  logic                int_pending_i,
    input  logic                status_ie_i,
    input  logic                status_exl_i,
    input  cp0_pkg::cp0_word_t  ebase_i,
    input  cp0_pkg::cp0_word_t  epc_i,
    output logic                enter_o,
    output cp0_pkg::exc_code_t  enter_code_o,
    output cp0_pkg::cp0_word_t  enter_pc_o,
    output logic                enter_bd_o,
    output cp0_pkg::cp0_word_t  enter_badvaddr_o,
    output logic                leave_o,
    output logic                redirect_o,
    output cp0_pkg::cp0_word_t  redirect_pc_o
);

    cp0_pkg::cp0_state_t state_q;
    cp0_pkg::cp0_state_t state_d;

    // captured exception record
    cp0_pkg::exc_code_t code_q;
    cp0_pkg::cp0_word_t pc_q;
    logic               bd_q;
    cp0_pkg::cp0_word_t badvaddr_q;

    logic take_exc;
    logic take_int;

    // requests arriving with EXL set are dropped
    assign take_exc = (state_q == cp0_pkg::ST_RUN) && !status_exl_i && exc_req_i;
    assign take_int = (state_q == cp0_pkg::ST_RUN) && !status_exl_i && !exc_req_i
                      && status_ie_i && int_pending_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            cp0_pkg::ST_RUN: begin
                if (take_exc || take_int) state_d = cp0_pkg::ST_ENTER;
            end
            cp0_pkg::ST_ENTER:   state_d = cp0_pkg::ST_HANDLER;
            cp0_pkg::ST_HANDLER: begin
                if (eret_i) state_d = cp0_pkg::ST_RETURN;
            end
            cp0_pkg::ST_RETURN:  state_d = cp0_pkg::ST_RUN;
            default:             state_d = cp0_pkg::ST_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cp0_pkg::ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (take_exc) begin
            code_q     <= exc_code_i;
            pc_q       <= exc_pc_i;
            bd_q       <= exc_bd_i;
            badvaddr_q <= bad_vaddr_i;
        end else if (take_int) begin
            code_q     <= cp0_pkg::EXC_INT;
            pc_q       <= cur_pc_i;  // restart at the interrupted instruction
            bd_q       <= 1'b0;
        end
    end

    assign enter_o          = (state_q == cp0_pkg::ST_ENTER);
    assign leave_o          = (state_q == cp0_pkg::ST_RETURN);
    assign enter_code_o     = code_q;
    assign enter_pc_o       = pc_q;
    assign enter_bd_o       = bd_q;
    assign enter_badvaddr_o = badvaddr_q;

    assign redirect_o    = enter_o || leave_o;
    assign redirect_pc_o = enter_o ? (ebase_i + cp0_pkg::EXC_VECTOR_OFFSET) : epc_i;

    // fetch redirect is always a single pulse
    a_redirect_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_o |=> !redirect_o
    );

    a_enter_leave_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(enter_o && leave_o)
    );

endmodule

//--- logic/cp0_pkg.sv
package cp0_pkg;

    // word and field types
    typedef logic [31:0] cp0_word_t;
    typedef logic [4:0]  cp0_addr_t;
    typedef logic [4:0]  exc_code_t;

    // register numbers
    localparam cp0_addr_t CP0_INDEX    = 5'd0;
    localparam cp0_addr_t CP0_ENTRYLO0 = 5'd2;
    localparam cp0_addr_t CP0_ENTRYLO1 = 5'd3;
    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_COUNT    = 5'd9;
    localparam cp0_addr_t CP0_ENTRYHI  = 5'd10;
    localparam cp0_addr_t CP0_COMPARE  = 5'd11;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;
    localparam cp0_addr_t CP0_EBASE    = 5'd15;

    // Cause.ExcCode values
    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_ADEL = 5'd4;  // address error on load or fetch
    localparam exc_code_t EXC_ADES = 5'd5;  // address error on store
    localparam exc_code_t EXC_SYS  = 5'd8;

    // reset words
    localparam cp0_word_t STATUS_RESET = 32'h1000_0000;
    localparam cp0_word_t EBASE_RESET  = 32'h8000_0000;

    // general exception vector sits at EBase + 0x180
    localparam cp0_word_t EXC_VECTOR_OFFSET = 32'h0000_0180;

    // exception controller states
    typedef enum logic [1:0] {
        ST_RUN,
        ST_ENTER,
        ST_HANDLER,
        ST_RETURN
    } cp0_state_t;

endpackage

//--- logic/cp0_regfile.sv
`timescale 1ns/1ps

module cp0_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we_i,
    input  cp0_pkg::cp0_addr_t  wr_addr_i,
    input  cp0_pkg::cp0_word_t  wr_data_i,
    input  cp0_pkg::cp0_addr_t  rd_addr_i,
    input  cp0_pkg::cp0_word_t  count_i,
    input  cp0_pkg::cp0_word_t  compare_i,
    input  logic                timer_int_i,
    input  logic                enter_i,
    input  cp0_pkg::exc_code_t  enter_code_i,
    input  cp0_pkg::cp0_word_t  enter_pc_i,
    input  logic                enter_bd_i,
    input  cp0_pkg::cp0_word_t  enter_badvaddr_i,
    input  logic                leave_i,
    output cp0_pkg::cp0_word_t  rd_data_o,
    output logic                status_ie_o,
    output logic                status_exl_o,
    output cp0_pkg::cp0_word_t  ebase_o,
    output cp0_pkg::cp0_word_t  epc_o,
    output logic                int_pending_o
);

    // TLB side, storage only
    logic [3:0]  index_q;
    logic [23:0] lo0_pfn_q;
    logic [1:0]  lo0_flags_q;  // D and V
    logic [23:0] lo1_pfn_q;
    logic [1:0]  lo1_flags_q;
    logic [18:0] entryhi_vpn2_q;

    cp0_pkg::cp0_word_t epc_q;
    cp0_pkg::cp0_word_t badvaddr_q;
    cp0_pkg::cp0_word_t ebase_q;

    logic [1:0] status_ksu_q;
    logic       status_exl_q;
    logic       status_ie_q;

    logic               cause_bd_q;
    logic [1:0]         cause_ip_q;  // software IP1..IP0
    cp0_pkg::exc_code_t cause_exc_q;

    logic [7:0] cause_ip;
    logic       load_badvaddr;

    function automatic logic wr_hit(input cp0_pkg::cp0_addr_t addr);
        return we_i && (wr_addr_i == addr);
    endfunction

    assign load_badvaddr = enter_i && ((enter_code_i == cp0_pkg::EXC_ADEL)
                                    || (enter_code_i == cp0_pkg::EXC_ADES));

    always_ff @(posedge clk) begin
        if (wr_hit(cp0_pkg::CP0_INDEX)) index_q <= wr_data_i[3:0];
        if (wr_hit(cp0_pkg::CP0_ENTRYLO0)) begin
            lo0_pfn_q   <= wr_data_i[29:6];
            lo0_flags_q <= wr_data_i[2:1];
        end
        if (wr_hit(cp0_pkg::CP0_ENTRYLO1)) begin
            lo1_pfn_q   <= wr_data_i[29:6];
            lo1_flags_q <= wr_data_i[2:1];
        end
        if (wr_hit(cp0_pkg::CP0_ENTRYHI)) entryhi_vpn2_q <= wr_data_i[31:13];
        // exception entry overrides a software write in the same cycle
        if (enter_i) begin
            epc_q <= enter_pc_i;
        end else if (wr_hit(cp0_pkg::CP0_EPC)) begin
            epc_q <= wr_data_i;
        end
        if (load_badvaddr) begin
            badvaddr_q <= enter_badvaddr_i;
        end else if (wr_hit(cp0_pkg::CP0_BADVADDR)) begin
            badvaddr_q <= wr_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ebase_q <= cp0_pkg::EBASE_RESET;
        end else if (wr_hit(cp0_pkg::CP0_EBASE)) begin
            ebase_q[29:12] <= wr_data_i[29:12];  // upper two bits fixed
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_ksu_q <= cp0_pkg::STATUS_RESET[4:3];
            status_exl_q <= cp0_pkg::STATUS_RESET[1];
            status_ie_q  <= cp0_pkg::STATUS_RESET[0];
        end else begin
            if (wr_hit(cp0_pkg::CP0_STATUS)) begin
                status_ksu_q <= wr_data_i[4:3];
                status_exl_q <= wr_data_i[1];
                status_ie_q  <= wr_data_i[0];
            end
            if (enter_i) status_exl_q <= 1'b1;  // hardware wins
            else if (leave_i) status_exl_q <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cause_bd_q  <= 1'b0;
            cause_ip_q  <= '0;
            cause_exc_q <= '0;
        end else begin
            if (wr_hit(cp0_pkg::CP0_CAUSE)) cause_ip_q <= wr_data_i[9:8];
            if (enter_i) begin
                cause_bd_q  <= enter_bd_i;
                cause_exc_q <= enter_code_i;
            end
        end
    end

    // IP7 is the timer, IP6..IP2 have no source here
    assign cause_ip = {timer_int_i, 5'b0, cause_ip_q};

    always_comb begin
        case (rd_addr_i)
            cp0_pkg::CP0_INDEX:    rd_data_o = {28'b0, index_q};
            cp0_pkg::CP0_ENTRYLO0: rd_data_o = {2'b0, lo0_pfn_q, 3'b0, lo0_flags_q, 1'b0};
            cp0_pkg::CP0_ENTRYLO1: rd_data_o = {2'b0, lo1_pfn_q, 3'b0, lo1_flags_q, 1'b0};
            cp0_pkg::CP0_BADVADDR: rd_data_o = badvaddr_q;
            cp0_pkg::CP0_COUNT:    rd_data_o = count_i;
            cp0_pkg::CP0_ENTRYHI:  rd_data_o = {entryhi_vpn2_q, 13'b0};
            cp0_pkg::CP0_COMPARE:  rd_data_o = compare_i;
            cp0_pkg::CP0_STATUS: begin
                rd_data_o = {27'b0, status_ksu_q, 1'b0, status_exl_q, status_ie_q};
            end
            cp0_pkg::CP0_CAUSE: begin
                rd_data_o = {cause_bd_q, 15'b0, cause_ip, 1'b0, cause_exc_q, 2'b0};
            end
            cp0_pkg::CP0_EPC:      rd_data_o = epc_q;
            cp0_pkg::CP0_EBASE:    rd_data_o = {2'b10, ebase_q[29:12], 12'b0};
            default:               rd_data_o = '0;
        endcase
    end

    assign status_ie_o   = status_ie_q;
    assign status_exl_o  = status_exl_q;
    assign ebase_o       = ebase_q;
    assign epc_o         = epc_q;
    assign int_pending_o = |cause_ip;

    // vector base must stay in kseg0/kseg1
    a_ebase_top: assert property (
        @(posedge clk) disable iff (!rst_n)
        ebase_o[31:30] == 2'b10
    );

endmodule

//--- logic/cp0_timer.sv
`timescale 1ns/1ps

module cp0_timer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              we_i,
    input  cp0_pkg::cp0_addr_t wr_addr_i,
    input  cp0_pkg::cp0_word_t wr_data_i,
    output cp0_pkg::cp0_word_t count_o,
    output cp0_pkg::cp0_word_t compare_o,
    output logic              timer_int_o
);

    cp0_pkg::cp0_word_t count_q;
    cp0_pkg::cp0_word_t compare_q;
    logic               timer_int_q;

    logic count_we;
    logic compare_we;
    logic match;

    assign count_we   = we_i && (wr_addr_i == cp0_pkg::CP0_COUNT);
    assign compare_we = we_i && (wr_addr_i == cp0_pkg::CP0_COMPARE);

    // a zero Compare never fires
    assign match = (compare_q != '0) && (compare_q == count_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (count_we) begin
            count_q <= wr_data_i;
        end else begin
            count_q <= count_q + 32'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            compare_q <= '0;
        end else if (compare_we) begin
            compare_q <= wr_data_i;
        end
    end

    // sticky flag, compare write clears it and beats a match
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_int_q <= 1'b0;
        end else if (compare_we) begin
            timer_int_q <= 1'b0;
        end else if (match) begin
            timer_int_q <= 1'b1;
        end
    end

    assign count_o     = count_q;
    assign compare_o   = compare_q;
    assign timer_int_o = timer_int_q;

    // acknowledge by Compare write must drop the interrupt
    a_compare_write_clears: assert property (
        @(posedge clk) disable iff (!rst_n)
        compare_we |=> !timer_int_o
    );

endmodule

//--- logic/cp0_top.sv
`timescale 1ns/1ps

module cp0_top (
    input  logic                clk,
    input  logic                rst_n,
    input  cp0_pkg::cp0_addr_t  rd_addr_i,
    input  logic                we_i,
    input  cp0_pkg::cp0_addr_t  wr_addr_i,
    input  cp0_pkg::cp0_word_t  wr_data_i,
    input  logic                exc_req_i,
    input  cp0_pkg::exc_code_t  exc_code_i,
    input  cp0_pkg::cp0_word_t  exc_pc_i,
    input  logic                exc_bd_i,
    input  cp0_pkg::cp0_word_t  bad_vaddr_i,
    input  cp0_pkg::cp0_word_t  cur_pc_i,
    input  logic                eret_i,
    output cp0_pkg::cp0_word_t  rd_data_o,
    output logic                redirect_o,
    output cp0_pkg::cp0_word_t  redirect_pc_o,
    output logic                timer_int_o
);

    cp0_pkg::cp0_word_t count;
    cp0_pkg::cp0_word_t compare;
    logic               timer_int;

    logic               status_ie;
    logic               status_exl;
    logic               int_pending;
    cp0_pkg::cp0_word_t ebase;
    cp0_pkg::cp0_word_t epc;

    // exception record from controller to register file
    logic               enter;
    cp0_pkg::exc_code_t enter_code;
    cp0_pkg::cp0_word_t enter_pc;
    logic               enter_bd;
    cp0_pkg::cp0_word_t enter_badvaddr;
    logic               leave;

    cp0_timer cp0_timer_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .we_i        (we_i),
        .wr_addr_i   (wr_addr_i),
        .wr_data_i   (wr_data_i),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int)
    );

    cp0_exc_ctrl cp0_exc_ctrl_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .exc_req_i        (exc_req_i),
        .exc_code_i       (exc_code_i),
        .exc_pc_i         (exc_pc_i),
        .exc_bd_i         (exc_bd_i),
        .bad_vaddr_i      (bad_vaddr_i),
        .cur_pc_i         (cur_pc_i),
        .eret_i           (eret_i),
        .int_pending_i    (int_pending),
        .status_ie_i      (status_ie),
        .status_exl_i     (status_exl),
        .ebase_i          (ebase),
        .epc_i            (epc),
        .enter_o          (enter),
        .enter_code_o     (enter_code),
        .enter_pc_o       (enter_pc),
        .enter_bd_o       (enter_bd),
        .enter_badvaddr_o (enter_badvaddr),
        .leave_o          (leave),
        .redirect_o       (redirect_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    cp0_regfile cp0_regfile_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .we_i             (we_i),
        .wr_addr_i        (wr_addr_i),
        .wr_data_i        (wr_data_i),
        .rd_addr_i        (rd_addr_i),
        .count_i          (count),
        .compare_i        (compare),
        .timer_int_i      (timer_int),
        .enter_i          (enter),
        .enter_code_i     (enter_code),
        .enter_pc_i       (enter_pc),
        .enter_bd_i       (enter_bd),
        .enter_badvaddr_i (enter_badvaddr),
        .leave_i          (leave),
        .rd_data_o        (rd_data_o),
        .status_ie_o      (status_ie),
        .status_exl_o     (status_exl),
        .ebase_o          (ebase),
        .epc_o            (epc),
        .int_pending_o    (int_pending)
    );

    assign timer_int_o = timer_int;

endmodule

//--- src.f
logic/cp0_pkg.sv
logic/cp0_timer.sv
logic/cp0_exc_ctrl.sv
logic/cp0_regfile.sv
logic/cp0_top.sv
testbench/tb_cp0_checks.sv
testbench/tb_cp0.sv

//--- testbench/tb_cp0.sv
`timescale 1ns/1ps

module tb_cp0;

    localparam int TIMEOUT_CYCLES = 3000;  // tests take roughly 700 cycles

    logic               clk;
    logic               rst_n;
    cp0_pkg::cp0_addr_t rd_addr_i;
    logic               we_i;
    cp0_pkg::cp0_addr_t wr_addr_i;
    cp0_pkg::cp0_word_t wr_data_i;
    logic               exc_req_i;
    cp0_pkg::exc_code_t exc_code_i;
    cp0_pkg::cp0_word_t exc_pc_i;
    logic               exc_bd_i;
    cp0_pkg::cp0_word_t bad_vaddr_i;
    cp0_pkg::cp0_word_t cur_pc_i;
    logic               eret_i;
    cp0_pkg::cp0_word_t rd_data_o;
    logic               redirect_o;
    cp0_pkg::cp0_word_t redirect_pc_o;
    logic               timer_int_o;
    logic               check_failed;
    cp0_pkg::cp0_word_t data;
    int                 cycle_count = 0;
    cp0_pkg::exc_code_t codes [3] = '{cp0_pkg::EXC_SYS, cp0_pkg::EXC_ADEL, cp0_pkg::EXC_ADES};

    cp0_top cp0_top_inst (.*);

    tb_cp0_checks checks_inst (
        .*,
        .rd_data_i      (rd_data_o),
        .redirect_i     (redirect_o),
        .redirect_pc_i  (redirect_pc_o),
        .timer_int_i    (timer_int_o),
        .check_failed_o (check_failed)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the run was still going after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    always @(posedge check_failed) begin
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first failed check");
    end

    task automatic write_reg(input cp0_pkg::cp0_addr_t addr, input cp0_pkg::cp0_word_t value);
        we_i      = 1'b1;
        wr_addr_i = addr;
        wr_data_i = value;
        rd_addr_i = addr;  // read back follows in the next cycle
        @(negedge clk);
        we_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic read_reg(input cp0_pkg::cp0_addr_t addr);
        rd_addr_i = addr;
        @(negedge clk);
    endtask

    task automatic raise_exception(input cp0_pkg::exc_code_t code);
        exc_req_i   = 1'b1;
        exc_code_i  = code;
        exc_pc_i    = $urandom & 32'hffff_fffc;
        exc_bd_i    = $urandom_range(1, 0);
        bad_vaddr_i = $urandom;
        @(negedge clk);
        exc_req_i = 1'b0;
        while (!redirect_o) @(negedge clk);
    endtask

    task automatic return_from_handler();
        eret_i = 1'b1;
        @(negedge clk);
        eret_i = 1'b0;
        while (!redirect_o) @(negedge clk);
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'hf089_8952));
        rst_n       = 1'b0;
        rd_addr_i   = cp0_pkg::CP0_STATUS;
        we_i        = 1'b0;
        wr_addr_i   = '0;
        wr_data_i   = '0;
        exc_req_i   = 1'b0;
        exc_code_i  = '0;
        exc_pc_i    = '0;
        exc_bd_i    = 1'b0;
        bad_vaddr_i = '0;
        cur_pc_i    = '0;
        eret_i      = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // every address, known or not, written with random data and read back
        repeat (8) begin
            for (int a = 0; a < 32; a++) begin
                data = $urandom;
                if (a == cp0_pkg::CP0_STATUS) data[0] = 1'b0;  // IE off
                write_reg(cp0_pkg::cp0_addr_t'(a), data);
            end
        end
        write_reg(cp0_pkg::CP0_STATUS, '0);
        write_reg(cp0_pkg::CP0_CAUSE, '0);

        read_reg(cp0_pkg::CP0_COUNT);
        repeat (6) @(negedge clk);
        write_reg(cp0_pkg::CP0_COUNT, $urandom);
        repeat (6) @(negedge clk);

        write_reg(cp0_pkg::CP0_COUNT, 32'd1000);
        write_reg(cp0_pkg::CP0_COMPARE, 32'd1040);
        rd_addr_i = cp0_pkg::CP0_CAUSE;
        while (!timer_int_o) @(negedge clk);
        repeat (4) @(negedge clk);
        write_reg(cp0_pkg::CP0_COMPARE, '0);  // acknowledge

        write_reg(cp0_pkg::CP0_EBASE, $urandom);
        foreach (codes[i]) begin
            raise_exception(codes[i]);
            read_reg(cp0_pkg::CP0_EPC);
            read_reg(cp0_pkg::CP0_CAUSE);
            read_reg(cp0_pkg::CP0_BADVADDR);
            exc_req_i   = 1'b1;  // nested request, dropped
            bad_vaddr_i = $urandom;
            read_reg(cp0_pkg::CP0_STATUS);
            exc_req_i = 1'b0;
            read_reg(cp0_pkg::CP0_BADVADDR);
            return_from_handler();
            read_reg(cp0_pkg::CP0_STATUS);
        end
        eret_i = 1'b1;
        read_reg(cp0_pkg::CP0_STATUS);
        eret_i = 1'b0;
        read_reg(cp0_pkg::CP0_STATUS);

        // timer interrupt with IE on, then a software interrupt
        write_reg(cp0_pkg::CP0_STATUS, 32'h0000_0001);
        cur_pc_i = $urandom & 32'hffff_fffc;
        write_reg(cp0_pkg::CP0_COUNT, 32'd2000);
        write_reg(cp0_pkg::CP0_COMPARE, 32'd2030);
        while (!redirect_o) @(negedge clk);
        read_reg(cp0_pkg::CP0_CAUSE);
        read_reg(cp0_pkg::CP0_EPC);
        write_reg(cp0_pkg::CP0_COMPARE, '0);
        return_from_handler();
        cur_pc_i = $urandom & 32'hffff_fffc;
        write_reg(cp0_pkg::CP0_CAUSE, 32'h0000_0100);
        while (!redirect_o) @(negedge clk);
        read_reg(cp0_pkg::CP0_EPC);
        write_reg(cp0_pkg::CP0_CAUSE, '0);
        return_from_handler();
        write_reg(cp0_pkg::CP0_STATUS, '0);
        repeat (4) @(negedge clk);

        if (check_failed) begin
            $display("TEST FAILED");
            $fatal(1, "a check reported a mismatch");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- testbench/tb_cp0_checks.sv
`timescale 1ns/1ps

module tb_cp0_checks (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we_i,
    input  cp0_pkg::cp0_addr_t wr_addr_i,
    input  cp0_pkg::cp0_word_t wr_data_i,
    input  cp0_pkg::cp0_addr_t rd_addr_i,
    input  logic               exc_req_i,
    input  cp0_pkg::exc_code_t exc_code_i,
    input  cp0_pkg::cp0_word_t exc_pc_i,
    input  logic               exc_bd_i,
    input  cp0_pkg::cp0_word_t bad_vaddr_i,
    input  cp0_pkg::cp0_word_t cur_pc_i,
    input  logic               eret_i,
    input  cp0_pkg::cp0_word_t rd_data_i,
    input  logic               redirect_i,
    input  cp0_pkg::cp0_word_t redirect_pc_i,
    input  logic               timer_int_i,
    output logic               check_failed_o
);

    cp0_pkg::cp0_word_t  shadow [0:31];  // last written words, masked on read
    cp0_pkg::cp0_word_t  m_count;
    cp0_pkg::cp0_word_t  m_pc;
    cp0_pkg::cp0_word_t  m_bad;
    cp0_pkg::exc_code_t  m_code;
    cp0_pkg::cp0_state_t m_state;
    cp0_pkg::cp0_word_t  exp_rd;
    cp0_pkg::cp0_word_t  ebase_rd;
    cp0_pkg::cp0_word_t  exp_target;
    logic [31:0]         known;  // register holds a defined value
    logic                m_timer;
    logic                m_bd;
    logic                m_exl;
    logic                m_take;
    logic                rd_known;

    assign m_exl  = shadow[cp0_pkg::CP0_STATUS][1];
    // exception request, or an enabled interrupt from the timer or a software IP bit
    assign m_take = exc_req_i || (shadow[cp0_pkg::CP0_STATUS][0]
                    && (m_timer || shadow[cp0_pkg::CP0_CAUSE][9:8] != 2'b00));

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            known   <= ~32'h0000_450d;  // Index, EntryLo, BadVAddr, EntryHi, EPC start undefined
            shadow[cp0_pkg::CP0_COMPARE] <= '0;
            shadow[cp0_pkg::CP0_STATUS]  <= cp0_pkg::STATUS_RESET;
            shadow[cp0_pkg::CP0_CAUSE]   <= '0;
            shadow[cp0_pkg::CP0_EBASE]   <= cp0_pkg::EBASE_RESET;
            m_count <= '0;
            m_timer <= 1'b0;
            m_state <= cp0_pkg::ST_RUN;
        end else begin
            m_count <= m_count + 32'd1;
            if (we_i) begin
                known[wr_addr_i] <= 1'b1;
                if (wr_addr_i == cp0_pkg::CP0_COUNT) m_count <= wr_data_i;
                else if (wr_addr_i == cp0_pkg::CP0_CAUSE) shadow[13][9:8] <= wr_data_i[9:8];
                else shadow[wr_addr_i] <= wr_data_i;
            end
            if (we_i && wr_addr_i == cp0_pkg::CP0_COMPARE) m_timer <= 1'b0;
            else if (shadow[11] != '0 && shadow[11] == m_count) m_timer <= 1'b1;
            case (m_state)
                cp0_pkg::ST_RUN: begin
                    if (!m_exl && m_take) begin
                        m_state <= cp0_pkg::ST_ENTER;
                        m_code  <= exc_req_i ? exc_code_i : cp0_pkg::EXC_INT;
                        m_pc    <= exc_req_i ? exc_pc_i : cur_pc_i;
                        m_bd    <= exc_req_i && exc_bd_i;
                        m_bad   <= bad_vaddr_i;
                    end
                end
                cp0_pkg::ST_ENTER: begin  // hardware updates land after the redirect cycle
                    m_state    <= cp0_pkg::ST_HANDLER;
                    known[14]  <= 1'b1;
                    shadow[14] <= m_pc;
                    shadow[13][31]  <= m_bd;
                    shadow[13][6:2] <= m_code;
                    shadow[12][1]   <= 1'b1;
                    if (m_code == cp0_pkg::EXC_ADEL || m_code == cp0_pkg::EXC_ADES) begin
                        known[8]  <= 1'b1;
                        shadow[8] <= m_bad;
                    end
                end
                cp0_pkg::ST_HANDLER: if (eret_i) m_state <= cp0_pkg::ST_RETURN;
                default: begin
                    m_state       <= cp0_pkg::ST_RUN;
                    shadow[12][1] <= 1'b0;
                end
            endcase
        end
    end

    assign ebase_rd   = 32'h8000_0000 | (shadow[cp0_pkg::CP0_EBASE] & 32'h3fff_f000);
    assign exp_target = (m_state == cp0_pkg::ST_ENTER)
                        ? ebase_rd + cp0_pkg::EXC_VECTOR_OFFSET : shadow[cp0_pkg::CP0_EPC];

    always_comb begin
        rd_known = known[rd_addr_i];
        case (rd_addr_i)
            cp0_pkg::CP0_INDEX:    exp_rd = shadow[rd_addr_i] & 32'h0000_000f;
            cp0_pkg::CP0_ENTRYLO0,
            cp0_pkg::CP0_ENTRYLO1: exp_rd = shadow[rd_addr_i] & 32'h3fff_ffc6;
            cp0_pkg::CP0_COUNT:    exp_rd = m_count;
            cp0_pkg::CP0_ENTRYHI:  exp_rd = shadow[rd_addr_i] & 32'hffff_e000;
            cp0_pkg::CP0_STATUS:   exp_rd = shadow[rd_addr_i] & 32'h0000_001b;
            cp0_pkg::CP0_CAUSE:    exp_rd = (shadow[rd_addr_i] & 32'h8000_7f7c) | {m_timer, 15'b0};
            cp0_pkg::CP0_EBASE:    exp_rd = ebase_rd;
            cp0_pkg::CP0_BADVADDR,
            cp0_pkg::CP0_COMPARE,
            cp0_pkg::CP0_EPC:      exp_rd = shadow[rd_addr_i];
            default:               exp_rd = '0;
        endcase
    end

    initial check_failed_o = 1'b0;

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        check_failed_o = 1'b1;
    endtask

    a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
        rd_known |-> rd_data_i == exp_rd)
        else report_mismatch($sformatf("register %0d read %h, expected %h",
            $sampled(rd_addr_i), $sampled(rd_data_i), $sampled(exp_rd)));

    a_count_step: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_addr_i == cp0_pkg::CP0_COUNT && !(we_i && wr_addr_i == cp0_pkg::CP0_COUNT))
        ##1 (rd_addr_i == cp0_pkg::CP0_COUNT) |-> rd_data_i == $past(rd_data_i) + 32'd1)
        else report_mismatch("Count did not advance by one between reads");

    a_timer_int: assert property (@(posedge clk) disable iff (!rst_n) timer_int_i == m_timer)
        else report_mismatch($sformatf("timer_int_o is %b, expected %b",
            $sampled(timer_int_i), $sampled(m_timer)));

    a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_i == (m_state == cp0_pkg::ST_ENTER || m_state == cp0_pkg::ST_RETURN))
        else report_mismatch($sformatf("redirect_o is %b in the wrong cycle", $sampled(redirect_i)));

    a_redirect_pc: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_i |-> redirect_pc_i == exp_target)
        else report_mismatch($sformatf("redirect_pc_o is %h, expected %h",
            $sampled(redirect_pc_i), $sampled(exp_target)));

endmodule
